/* filelist.f */
+incdir+bench
verilog/lisp_pkg.sv
verilog/lisp_if.sv
verilog/fetch_unit.sv
verilog/stack_alu.sv
verilog/stack_regs.sv
verilog/core_control.sv
verilog/lisp_memory.sv
verilog/lisp_core.sv
bench/tb_lisp_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; the exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
	-f filelist.f \
	--top-module tb_lisp_core \
	--Mdir obj_dir \
	-o tb_lisp_core &&
./obj_dir/tb_lisp_core || exit 1

/* bench/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH
`default_nettype none

// Program image, one entry per word from address 0
word_t prog[$];

// Parameter opcode alone in slot 0, its 15-bit parameter fills the word
function automatic word_t op_param(opcode_e op, data_t p);
	return {op, p[14:0]};
endfunction

// Plain opcode in slot 0, the three NOP slots after it do nothing
function automatic word_t op_plain(opcode_e op);
	return {op, 15'd0};
endfunction

// Data address of a window register, reachable by a negative PUSH parameter
function automatic data_t win_addr(int idx);
	return 16'hff80 + data_t'(idx);
endfunction

function automatic void emit(word_t w);
	prog.push_back(w);
endfunction

// Store a constant to window register idx
function automatic void emit_report(data_t val, int idx);
	emit(op_param(OP_PUSH, val));
	emit(op_param(OP_PUSH, win_addr(idx)));
	emit(op_plain(OP_STORE));
endfunction

function automatic void emit_halt();
	emit(op_param(OP_GOTO, 16'd0));
endfunction

// Store v to RAM, load it back, DUP and POP around it, report both copies
function automatic void build_memory(data_t v);
	prog.delete();
	emit(op_param(OP_PUSH, v));
	emit(op_param(OP_PUSH, 16'd100));
	emit(op_plain(OP_STORE));
	emit(op_param(OP_PUSH, 16'd100));
	emit(op_plain(OP_LOAD));
	emit(op_plain(OP_DUP));
	emit(op_param(OP_PUSH, 16'd77));
	emit(op_plain(OP_POP));
	emit(op_param(OP_PUSH, win_addr(0)));
	emit(op_plain(OP_STORE));
	emit(op_param(OP_PUSH, win_addr(1)));
	emit(op_plain(OP_STORE));
	emit_halt();
endfunction

// Branches and a countdown loop; word numbers are noted for the offsets
function automatic void build_flow(data_t n);
	prog.delete();
	emit(op_param(OP_PUSH, 16'd0));
	emit(op_param(OP_BFALSE, 16'd4));
	emit_report(16'h111, 9);
	emit_report(16'd1, 1);
	emit(op_param(OP_PUSH, 16'd7));
	emit(op_param(OP_BFALSE, 16'd4));
	emit_report(16'd2, 2);
	// Word 13
	emit(op_param(OP_GOTO, 16'd4));
	emit_report(16'h222, 9);
	emit_report(16'd3, 3);
	// Word 20, loop body starts at 21
	emit(op_param(OP_PUSH, n));
	emit(op_plain(OP_DUP));
	emit(op_param(OP_PUSH, win_addr(4)));
	emit(op_plain(OP_STORE));
	emit(op_param(OP_PUSH, 16'hffff));
	emit(op_plain(OP_ADD));
	emit(op_plain(OP_DUP));
	emit(op_param(OP_BFALSE, 16'd2));
	emit(op_param(OP_GOTO, -16'sd7));
	emit_report(16'h55, 6);
	emit_halt();
endfunction

// Caller at word 0, function at word 20 sums its two arguments
function automatic void build_frame(data_t a, data_t b, data_t marker);
	prog.delete();
	emit(op_param(OP_PUSH, a));
	emit(op_param(OP_PUSH, b));
	emit(op_param(OP_PUSH, 16'd20));
	emit(op_plain(OP_CALL));
	emit(op_param(OP_CLEANUP, 16'd2));
	emit(op_param(OP_PUSH, win_addr(0)));
	emit(op_plain(OP_STORE));
	emit_report(marker, 1);
	emit_halt();
	while (prog.size() < 20)
		emit(word_t'(0));
	emit(op_param(OP_RESERVE, 16'd1));
	emit(op_param(OP_GETLOCAL, 16'd2));
	emit(op_param(OP_GETLOCAL, 16'd1));
	emit(op_plain(OP_ADD));
	emit(op_param(OP_SETLOCAL, -16'sd2));
	emit(op_param(OP_GETLOCAL, -16'sd2));
	emit(op_plain(OP_RETURN));
endfunction

// Read window register j, add one, write it to register k
function automatic void build_regread(int j, int k);
	prog.delete();
	emit(op_param(OP_PUSH, win_addr(j)));
	emit(op_plain(OP_LOAD));
	emit(op_param(OP_PUSH, 16'd1));
	emit(op_plain(OP_ADD));
	emit(op_param(OP_PUSH, win_addr(k)));
	emit(op_plain(OP_STORE));
	emit_halt();
endfunction

`default_nettype wire
`endif

/* bench/tb_lisp_core.sv */
`default_nettype none

module tb_lisp_core;
	timeunit 1ns;
	timeprecision 100ps;

	import lisp_pkg::*;

	localparam int TIMEOUT = 2000;
	localparam opcode_e ALU_OPS [11] = '{OP_ADD, OP_SUB, OP_GTR, OP_GTE, OP_EQ, OP_NEQ,
		OP_AND, OP_OR, OP_XOR, OP_LSHIFT, OP_RSHIFT};

	logic                  clk = 1'b0;
	logic                  rst_i;
	logic                  boot_we_i;
	data_t                 boot_addr_i;
	word_t                 boot_data_i;
	logic                  io_we_o;
	logic                  io_re_o;
	logic [IO_INDEX_W-1:0] io_index_o;
	data_t                 io_wdata_o;
	data_t                 io_rdata_i;
	logic [15:0]           lfsr = 16'd53;

	`include "tb_programs.svh"

	lisp_core u_lisp_core (
		.clk(clk), .rst_i(rst_i), .boot_we_i(boot_we_i), .boot_addr_i(boot_addr_i),
		.boot_data_i(boot_data_i), .io_we_o(io_we_o), .io_re_o(io_re_o),
		.io_index_o(io_index_o), .io_wdata_o(io_wdata_o), .io_rdata_i(io_rdata_i)
	);

	always #5 clk = ~clk;

	// Galois LFSR, one step per bit taken
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hb400 : 16'h0000);
		return b;
	endfunction

	function automatic data_t rand_bits(int n);
		data_t v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[14:0], lfsr_bit()};
		return v;
	endfunction

	// Operands must fit a 15-bit PUSH parameter
	function automatic data_t rand_param();
		data_t v;
		v = rand_bits(15);
		return {v[14], v[14:0]};
	endfunction

	// x is TOS (pushed last), y is the word below it
	function automatic data_t alu_expect(opcode_e op, data_t x, data_t y);
		data_t d;
		d = x - y;
		case (op)
			OP_ADD:    return x + y;
			OP_SUB:    return d;
			OP_GTR:    return (!d[15] && d != 16'd0) ? 16'd1 : 16'd0;
			OP_GTE:    return !d[15] ? 16'd1 : 16'd0;
			OP_EQ:     return (d == 16'd0) ? 16'd1 : 16'd0;
			OP_NEQ:    return (d != 16'd0) ? 16'd1 : 16'd0;
			OP_AND:    return x & y;
			OP_OR:     return x | y;
			OP_XOR:    return x ^ y;
			OP_LSHIFT: return x << y;
			OP_RSHIFT: return x >> y;
			default:   return 16'd0;
		endcase
	endfunction

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_io_write(string test, logic [IO_INDEX_W-1:0] idx, data_t val);
		if (io_index_o !== idx || io_wdata_o !== val)
			fail_run($sformatf("MISMATCH %s: expected index %0d data %h, actual index %0d data %h",
				test, idx, val, io_index_o, io_wdata_o));
	endtask

	task automatic check_io_read(string test, logic [IO_INDEX_W-1:0] idx);
		if (io_index_o !== idx)
			fail_run($sformatf("MISMATCH %s: expected read index %0d, actual read index %0d",
				test, idx, io_index_o));
	endtask

	// Outputs are sampled at the falling edge, well away from input changes
	task automatic wait_io_write(string test);
		int i;
		for (i = 0; i < TIMEOUT; i++)
		begin
			@(negedge clk);
			if (io_we_o)
				break;
		end
		if (i == TIMEOUT)
			fail_run($sformatf("%s: no register write seen within %0d cycles", test, TIMEOUT));
	endtask

	task automatic wait_io_read(string test);
		int i;
		for (i = 0; i < TIMEOUT; i++)
		begin
			@(negedge clk);
			if (io_re_o)
				break;
		end
		if (i == TIMEOUT)
			fail_run($sformatf("%s: no register read seen within %0d cycles", test, TIMEOUT));
	endtask

	task automatic expect_write(string test, int idx, data_t val);
		wait_io_write(test);
		check_io_write(test, idx[IO_INDEX_W-1:0], val);
	endtask

	// Hold reset, load the image through the boot port, then release
	task automatic boot_program();
		@(posedge clk);
		#1;
		rst_i = 1'b1;
		foreach (prog[i])
		begin
			boot_we_i   = 1'b1;
			boot_addr_i = data_t'(i);
			boot_data_i = prog[i];
			@(posedge clk);
			#1;
		end
		boot_we_i = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst_i = 1'b0;
	endtask

	task automatic alu_ops();
		data_t a [11];
		data_t b [11];
		prog.delete();
		foreach (ALU_OPS[i])
		begin
			// Shift amount is the first push, kept below the data width
			a[i] = (ALU_OPS[i] inside {OP_LSHIFT, OP_RSHIFT}) ? rand_bits(4) : rand_param();
			// Equal operands reach the equality edge of GTE and EQ
			b[i] = (ALU_OPS[i] inside {OP_GTE, OP_EQ}) ? a[i] : rand_param();
			emit(op_param(OP_PUSH, a[i]));
			emit(op_param(OP_PUSH, b[i]));
			emit(op_plain(ALU_OPS[i]));
			emit(op_param(OP_PUSH, win_addr(i)));
			emit(op_plain(OP_STORE));
		end
		emit_halt();
		boot_program();
		foreach (ALU_OPS[i])
			expect_write($sformatf("alu %s", ALU_OPS[i].name()), i,
				alu_expect(ALU_OPS[i], b[i], a[i]));
	endtask

	task automatic memory_roundtrip();
		data_t v;
		v = rand_param();
		build_memory(v);
		boot_program();
		expect_write("memory", 0, v);
		expect_write("memory", 1, v);
	endtask

	task automatic run_flow_head(string test, data_t n);
		expect_write(test, 1, 16'd1);
		expect_write(test, 2, 16'd2);
		expect_write(test, 3, 16'd3);
		expect_write(test, 4, n);
	endtask

	task automatic branch_and_loop();
		data_t n;
		n = 16'd3 + rand_bits(2);
		build_flow(n);
		boot_program();
		run_flow_head("flow", n);
		for (int c = int'(n) - 1; c > 0; c--)
			expect_write("flow", 4, data_t'(c));
		expect_write("flow", 6, 16'h55);
	endtask

	task automatic call_frame();
		data_t a;
		data_t b;
		a = rand_param();
		b = rand_param();
		build_frame(a, b, 16'h1234);
		boot_program();
		expect_write("frame", 0, a + b);
		expect_write("frame", 1, 16'h1234);
	endtask

	task automatic window_read();
		data_t v;
		v = rand_bits(16);
		build_regread(5, 12);
		boot_program();
		io_rdata_i = v;
		wait_io_read("regread");
		check_io_read("regread", 7'd5);
		expect_write("regread", 12, v + 16'd1);
	endtask

	task automatic reset_mid_loop();
		build_flow(16'd6);
		boot_program();
		run_flow_head("reset", 16'd6);
		@(posedge clk);
		#1;
		rst_i = 1'b1;
		// Strobes must stay low for all of reset and one cycle after
		repeat (10)
		begin
			@(negedge clk);
			if (io_we_o || io_re_o)
				fail_run("reset: register strobe seen while reset was held");
		end
		@(posedge clk);
		#1;
		rst_i = 1'b0;
		@(negedge clk);
		if (io_we_o || io_re_o)
			fail_run("reset: register strobe seen in the first cycle after reset");
		expect_write("reset", 1, 16'd1);
		expect_write("reset", 2, 16'd2);
	endtask

	initial
	begin
		rst_i       = 1'b1;
		boot_we_i   = 1'b0;
		boot_addr_i = '0;
		boot_data_i = '0;
		io_rdata_i  = '0;
		repeat (10) @(posedge clk);
		alu_ops();
		memory_roundtrip();
		branch_and_loop();
		call_frame();
		window_read();
		reset_mid_loop();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/lisp_core.sv */
`default_nettype none

module lisp_core #(
	parameter int MEM_SIZE = 8192
) (
	input  logic                            clk,
	input  logic                            rst_i,
	input  logic                            boot_we_i,
	input  lisp_pkg::data_t                 boot_addr_i,
	input  lisp_pkg::word_t                 boot_data_i,
	output logic                            io_we_o,
	output logic                            io_re_o,
	output logic [lisp_pkg::IO_INDEX_W-1:0] io_index_o,
	output lisp_pkg::data_t                 io_wdata_o,
	input  lisp_pkg::data_t                 io_rdata_i
);
	import lisp_pkg::*;

	mem_bus_if mem_bus ();
	dp_ctrl_if dp_ctrl ();

	opcode_e opcode;
	data_t   param;
	data_t   fetch_addr;
	iptr_t   return_addr;
	word_t   tos;
	data_t   sp;
	data_t   sp_next;
	data_t   bp;
	data_t   alu_result;
	logic    rdata_sel;
	logic    in_decode;

	core_control u_core_control (
		.clk(clk), .rst_i(rst_i), .dp(dp_ctrl.ctrl), .bus(mem_bus.master),
		.opcode_i(opcode), .param_i(param), .fetch_addr_i(fetch_addr), .tos_i(tos),
		.sp_i(sp), .sp_next_i(sp_next), .bp_i(bp), .alu_result_i(alu_result),
		.rdata_sel_i(rdata_sel), .in_decode_o(in_decode)
	);

	fetch_unit u_fetch_unit (
		.clk(clk), .rst_i(rst_i), .dp(dp_ctrl.fetch), .rdata_i(mem_bus.rdata),
		.tos_i(tos), .in_decode_i(in_decode), .opcode_o(opcode), .param_o(param),
		.fetch_addr_o(fetch_addr), .return_addr_o(return_addr)
	);

	stack_alu u_stack_alu (
		.dp(dp_ctrl.alu), .tos_i(tos), .sp_i(sp), .bp_i(bp), .param_i(param),
		.rdata_i(mem_bus.rdata), .alu_result_o(alu_result)
	);

	stack_regs #(.MEM_SIZE(MEM_SIZE)) u_stack_regs (
		.clk(clk), .rst_i(rst_i), .dp(dp_ctrl.regs), .alu_result_i(alu_result),
		.param_i(param), .return_addr_i(return_addr), .rdata_i(mem_bus.rdata),
		.tos_o(tos), .sp_o(sp), .sp_next_o(sp_next), .bp_o(bp)
	);

	lisp_memory #(.MEM_SIZE(MEM_SIZE)) u_lisp_memory (
		.clk(clk), .rst_i(rst_i), .bus(mem_bus.slave), .boot_we_i(boot_we_i),
		.boot_addr_i(boot_addr_i), .boot_data_i(boot_data_i), .io_we_o(io_we_o),
		.io_re_o(io_re_o), .io_index_o(io_index_o), .io_wdata_o(io_wdata_o),
		.io_rdata_i(io_rdata_i), .rdata_sel_o(rdata_sel)
	);

endmodule

`default_nettype wire

/* verilog/lisp_memory.sv */
`default_nettype none

module lisp_memory #(
	parameter int MEM_SIZE = 8192
) (
	input  logic                            clk,
	input  logic                            rst_i,
	mem_bus_if.slave                        bus,
	input  logic                            boot_we_i,
	input  lisp_pkg::data_t                 boot_addr_i,
	input  lisp_pkg::word_t                 boot_data_i,
	output logic                            io_we_o,
	output logic                            io_re_o,
	output logic [lisp_pkg::IO_INDEX_W-1:0] io_index_o,
	output lisp_pkg::data_t                 io_wdata_o,
	input  lisp_pkg::data_t                 io_rdata_i,
	output logic                            rdata_sel_o
);
	import lisp_pkg::*;

	localparam int AW = $clog2(MEM_SIZE);

	word_t         ram [MEM_SIZE];
	word_t         ram_q;
	logic [AW-1:0] ram_addr;
	word_t         ram_wdata;
	logic          ram_we;
	logic          win_hit;

	assign win_hit = (bus.addr[15:7] == IO_PREFIX);

	// Boot port owns the RAM while reset is held
	assign ram_addr  = rst_i ? boot_addr_i[AW-1:0] : bus.addr[AW-1:0];
	assign ram_wdata = rst_i ? boot_data_i : bus.wdata;
	assign ram_we    = rst_i ? boot_we_i : (bus.we && !win_hit);

	assign io_we_o    = !rst_i && win_hit && bus.we;
	assign io_re_o    = !rst_i && win_hit && !bus.we;
	assign io_index_o = bus.addr[IO_INDEX_W-1:0];
	assign io_wdata_o = bus.wdata[15:0];

	always_ff @(posedge clk)
	begin
		if (ram_we)
			ram[ram_addr] <= ram_wdata;
		ram_q <= ram[ram_addr];
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			rdata_sel_o <= 1'b0;
		else
			rdata_sel_o <= io_re_o;
	end

	// Register data is sampled in the cycle after the read strobe
	assign bus.rdata = rdata_sel_o ? {4'b0, io_rdata_i} : ram_q;

endmodule

`default_nettype wire

/* verilog/core_control.sv */
`default_nettype none

module core_control (
	input  logic              clk,
	input  logic              rst_i,
	dp_ctrl_if.ctrl           dp,
	mem_bus_if.master         bus,
	input  lisp_pkg::opcode_e opcode_i,
	input  lisp_pkg::data_t   param_i,
	input  lisp_pkg::data_t   fetch_addr_i,
	input  lisp_pkg::word_t   tos_i,
	input  lisp_pkg::data_t   sp_i,
	input  lisp_pkg::data_t   sp_next_i,
	input  lisp_pkg::data_t   bp_i,
	input  lisp_pkg::data_t   alu_result_i,
	input  logic              rdata_sel_i,
	output logic              in_decode_o
);
	import lisp_pkg::*;

	state_e state;
	state_e state_next;

	assign in_decode_o = (state == ST_DECODE);
	assign dp.ir_load  = (state == ST_DECODE);

	// Every path into DECODE issues the fetch address
	always_comb
	begin
		state_next     = state;
		bus.addr       = fetch_addr_i;
		bus.wdata      = tos_i;
		bus.we         = 1'b0;
		dp.sp_sel      = SP_CUR;
		dp.tos_sel     = TOS_CUR;
		dp.op0_sel     = OP0_TOS;
		dp.op1_sel     = OP1_MEM;
		dp.alu_op      = opcode_i;
		dp.bp_load     = 1'b0;
		dp.ip_next_sel = IP_HOLD;

		case (state)
			ST_FETCH:
			begin
				dp.ip_next_sel = IP_SEQ;
				state_next     = ST_DECODE;
			end

			ST_DECODE:
			begin
				case (opcode_i)
					OP_CALL:
					begin
						// Save old BP below the stack, return address goes to TOS
						dp.ip_next_sel = IP_CALL;
						dp.sp_sel      = SP_DEC;
						bus.addr       = sp_next_i;
						bus.wdata      = word_t'(bp_i);
						bus.we         = 1'b1;
						dp.bp_load     = 1'b1;
						dp.tos_sel     = TOS_RET;
						state_next     = ST_CALL2;
					end
					OP_RETURN:
					begin
						// Return address was parked just under the frame link
						dp.alu_op  = OP_SUB;
						dp.op0_sel = OP0_BP;
						dp.op1_sel = OP1_ONE;
						bus.addr   = alu_result_i;
						state_next = ST_RETURN2;
					end
					OP_POP:
					begin
						bus.addr   = sp_i;
						dp.sp_sel  = SP_INC;
						state_next = ST_PUSH_MEM;
					end
					OP_LOAD:
					begin
						bus.addr   = tos_i[15:0];
						state_next = ST_PUSH_MEM;
					end
					OP_STORE, OP_ADD, OP_SUB, OP_GTR, OP_GTE, OP_EQ, OP_NEQ,
					OP_AND, OP_OR, OP_XOR, OP_LSHIFT, OP_RSHIFT:
					begin
						// Fetch next on stack first
						bus.addr   = sp_i;
						state_next = ST_GOT_NOS;
					end
					OP_DUP, OP_PUSH:
					begin
						dp.sp_sel  = SP_DEC;
						bus.addr   = sp_next_i;
						bus.we     = 1'b1;
						dp.tos_sel = (opcode_i == OP_PUSH) ? TOS_PARAM : TOS_CUR;
						state_next = ST_FETCH;
					end
					OP_RESERVE:
					begin
						if (param_i == '0)
						begin
							dp.ip_next_sel = IP_SEQ;
							state_next     = ST_DECODE;
						end
						else
						begin
							// Spill TOS, then drop SP by the local count
							bus.addr   = sp_i - 16'd1;
							bus.we     = 1'b1;
							dp.sp_sel  = SP_ALU;
							dp.alu_op  = OP_SUB;
							dp.op0_sel = OP0_SP;
							dp.op1_sel = OP1_PARAM;
							state_next = ST_FETCH;
						end
					end
					OP_GOTO:
					begin
						dp.ip_next_sel = IP_BRANCH;
						state_next     = ST_DECODE;
					end
					OP_BFALSE:
					begin
						// Branch is resolved while the new TOS is read
						dp.sp_sel  = SP_INC;
						bus.addr   = sp_i;
						state_next = ST_PUSH_MEM;
					end
					OP_GETLOCAL:
					begin
						dp.sp_sel  = SP_DEC;
						bus.addr   = sp_next_i;
						bus.we     = 1'b1;
						state_next = ST_GETLOCAL2;
					end
					OP_SETLOCAL:
					begin
						dp.alu_op  = OP_ADD;
						dp.op0_sel = OP0_BP;
						dp.op1_sel = OP1_PARAM;
						bus.addr   = alu_result_i;
						bus.we     = 1'b1;
						state_next = ST_LOAD_TOS;
					end
					OP_CLEANUP:
					begin
						// TOS holds the return value and stays put
						dp.sp_sel      = SP_ALU;
						dp.alu_op      = OP_ADD;
						dp.op0_sel     = OP0_SP;
						dp.op1_sel     = OP1_PARAM;
						dp.ip_next_sel = IP_SEQ;
						state_next     = ST_DECODE;
					end
					default:
					begin
						dp.ip_next_sel = IP_SEQ;
						state_next     = ST_DECODE;
					end
				endcase
			end

			ST_GOT_NOS:
			begin
				dp.sp_sel = SP_INC;
				if (opcode_i == OP_STORE)
				begin
					bus.addr   = tos_i[15:0];
					bus.wdata  = bus.rdata;
					bus.we     = 1'b1;
					state_next = ST_LOAD_TOS;
				end
				else
				begin
					dp.tos_sel     = TOS_ALU;
					dp.ip_next_sel = IP_SEQ;
					state_next     = ST_DECODE;
				end
			end

			ST_LOAD_TOS:
			begin
				bus.addr   = sp_i;
				dp.sp_sel  = SP_INC;
				state_next = ST_PUSH_MEM;
			end

			ST_GETLOCAL2:
			begin
				dp.alu_op  = OP_ADD;
				dp.op0_sel = OP0_BP;
				dp.op1_sel = OP1_PARAM;
				bus.addr   = alu_result_i;
				state_next = ST_PUSH_MEM;
			end

			ST_PUSH_MEM:
			begin
				dp.tos_sel = rdata_sel_i ? TOS_REG : TOS_MEM;
				if (opcode_i == OP_BFALSE && tos_i[15:0] == '0)
					dp.ip_next_sel = IP_BRANCH;
				else
					dp.ip_next_sel = IP_SEQ;
				state_next = ST_DECODE;
			end

			ST_RETURN2:
			begin
				// Frame link comes next, SP unwinds to just above it
				dp.ip_next_sel = IP_RETURN;
				bus.addr       = bp_i;
				dp.sp_sel      = SP_ALU;
				dp.alu_op      = OP_ADD;
				dp.op0_sel     = OP0_BP;
				dp.op1_sel     = OP1_ONE;
				state_next     = ST_RETURN3;
			end

			ST_RETURN3:
			begin
				dp.bp_load = 1'b1;
				state_next = ST_DECODE;
			end

			ST_CALL2:   state_next = ST_DECODE;

			default:    state_next = ST_FETCH;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
			state <= ST_FETCH;
		else
			state <= state_next;
	end

	// Single-port memory: a write cycle cannot also carry the fetch address
	a_no_write_on_fetch: assert property (@(posedge clk) disable iff (rst_i)
		!(bus.we && state_next == ST_DECODE));

endmodule

`default_nettype wire

/* verilog/stack_regs.sv */
`default_nettype none

module stack_regs #(
	parameter int MEM_SIZE = 8192
) (
	input  logic            clk,
	input  logic            rst_i,
	dp_ctrl_if.regs         dp,
	input  lisp_pkg::data_t alu_result_i,
	input  lisp_pkg::data_t param_i,
	input  lisp_pkg::iptr_t return_addr_i,
	input  lisp_pkg::word_t rdata_i,
	output lisp_pkg::word_t tos_o,
	output lisp_pkg::data_t sp_o,
	output lisp_pkg::data_t sp_next_o,
	output lisp_pkg::data_t bp_o
);
	import lisp_pkg::*;

	localparam data_t SP_RESET = data_t'(MEM_SIZE - 8);
	localparam data_t BP_RESET = data_t'(MEM_SIZE - 4);

	word_t tos_next;
	data_t bp_next;

	always_comb
	begin
		case (dp.sp_sel)
			SP_DEC:  sp_next_o = sp_o - 16'd1;
			SP_INC:  sp_next_o = sp_o + 16'd1;
			SP_ALU:  sp_next_o = alu_result_i;
			default: sp_next_o = sp_o;
		endcase
	end

	always_comb
	begin
		case (dp.tos_sel)
			TOS_RET:   tos_next = return_addr_i[19:0];
			TOS_PARAM: tos_next = {4'b0, param_i};
			TOS_ALU:   tos_next = {4'b0, alu_result_i};
			TOS_MEM:   tos_next = rdata_i;
			// Window registers are only 16 bits wide
			TOS_REG:   tos_next = {4'b0, rdata_i[15:0]};
			default:   tos_next = tos_o;
		endcase
	end

	// CALL links BP to the slot it pushes, RETURN restores it from memory
	always_comb
	begin
		if (!dp.bp_load)
			bp_next = bp_o;
		else if (dp.sp_sel == SP_DEC)
			bp_next = sp_next_o;
		else
			bp_next = rdata_i[15:0];
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			tos_o <= '0;
			sp_o  <= SP_RESET;
			bp_o  <= BP_RESET;
		end
		else
		begin
			tos_o <= tos_next;
			sp_o  <= sp_next_o;
			bp_o  <= bp_next;
		end
	end

	// Stack grows down, so popping past the initial SP means unbalanced frames
	a_sp_bounded: assert property (@(posedge clk) disable iff (rst_i) sp_o <= SP_RESET);

endmodule

`default_nettype wire

/* verilog/stack_alu.sv */
`default_nettype none

module stack_alu (
	dp_ctrl_if.alu          dp,
	input  lisp_pkg::word_t tos_i,
	input  lisp_pkg::data_t sp_i,
	input  lisp_pkg::data_t bp_i,
	input  lisp_pkg::data_t param_i,
	input  lisp_pkg::word_t rdata_i,
	output lisp_pkg::data_t alu_result_o
);
	import lisp_pkg::*;

	data_t op0;
	data_t op1;
	data_t diff;
	logic  zero;
	logic  neg;

	always_comb
	begin
		case (dp.op0_sel)
			OP0_TOS: op0 = tos_i[15:0];
			OP0_SP:  op0 = sp_i;
			OP0_BP:  op0 = bp_i;
			default: op0 = '0;
		endcase
		case (dp.op1_sel)
			OP1_MEM:   op1 = rdata_i[15:0];
			OP1_PARAM: op1 = param_i;
			OP1_ONE:   op1 = 16'd1;
			default:   op1 = '0;
		endcase
	end

	// Comparisons look at the sign and zero of the 16-bit difference
	assign diff = op0 - op1;
	assign zero = (diff == '0);
	assign neg  = diff[15];

	always_comb
	begin
		case (dp.alu_op)
			OP_ADD:    alu_result_o = op0 + op1;
			OP_SUB:    alu_result_o = diff;
			OP_GTR:    alu_result_o = {15'd0, !neg && !zero};
			OP_GTE:    alu_result_o = {15'd0, !neg};
			OP_EQ:     alu_result_o = {15'd0, zero};
			OP_NEQ:    alu_result_o = {15'd0, !zero};
			OP_AND:    alu_result_o = op0 & op1;
			OP_OR:     alu_result_o = op0 | op1;
			OP_XOR:    alu_result_o = op0 ^ op1;
			OP_LSHIFT: alu_result_o = op0 << op1;
			OP_RSHIFT: alu_result_o = op0 >> op1;
			default:   alu_result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
`default_nettype none

module fetch_unit (
	input  logic              clk,
	input  logic              rst_i,
	dp_ctrl_if.fetch          dp,
	input  lisp_pkg::word_t   rdata_i,
	input  lisp_pkg::word_t   tos_i,
	input  logic              in_decode_i,
	output lisp_pkg::opcode_e opcode_o,
	output lisp_pkg::data_t   param_o,
	output lisp_pkg::data_t   fetch_addr_o,
	output lisp_pkg::iptr_t   return_addr_o
);
	import lisp_pkg::*;

	iptr_t      ip;
	iptr_t      ip_next;
	iptr_t      word_base;
	iptr_t      seq_addr;
	iptr_t      branch_addr;
	word_t      ir;
	word_t      cur_word;
	logic [4:0] slot_opc;
	logic [4:0] prev_opc;

	// The word arrives on rdata during decode and is latched for later states
	assign cur_word = in_decode_i ? rdata_i : ir;

	always_comb
	begin
		case (ip[1:0])
			2'd0:
			begin
				slot_opc = cur_word[19:15];
				param_o  = {cur_word[14], cur_word[14:0]};
				prev_opc = 5'd0;
			end
			2'd1:
			begin
				slot_opc = cur_word[14:10];
				param_o  = {{6{cur_word[9]}}, cur_word[9:0]};
				prev_opc = cur_word[19:15];
			end
			2'd2:
			begin
				slot_opc = cur_word[9:5];
				param_o  = {{11{cur_word[4]}}, cur_word[4:0]};
				prev_opc = cur_word[14:10];
			end
			default:
			begin
				slot_opc = cur_word[4:0];
				param_o  = '0;
				prev_opc = cur_word[9:5];
			end
		endcase
	end

	assign opcode_o = opcode_e'(slot_opc);

	assign word_base     = {ip[21:2], 2'b00};
	assign return_addr_o = word_base + 22'd4;
	// A parameter consumes the rest of the word
	assign seq_addr      = (slot_opc[4:3] == PARAM_CLASS) ? return_addr_o : ip + 22'd1;
	assign branch_addr   = word_base + {{4{param_o[15]}}, param_o, 2'b00};

	always_comb
	begin
		case (dp.ip_next_sel)
			IP_SEQ:    ip_next = seq_addr;
			IP_BRANCH: ip_next = branch_addr;
			IP_CALL:   ip_next = {4'b0, tos_i[15:0], 2'b00};
			IP_RETURN: ip_next = {2'b00, rdata_i};
			default:   ip_next = ip;
		endcase
	end

	assign fetch_addr_o = ip_next[17:2];

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			// One slot before word 0, so the first fetch lands on slot 0
			ip <= '1;
			ir <= '0;
		end
		else
		begin
			ip <= ip_next;
			if (dp.ir_load)
				ir <= rdata_i;
		end
	end

	// Slots behind a parameter opcode are operand bits, never instructions
	a_no_slot_after_param: assert property (@(posedge clk) disable iff (rst_i)
		in_decode_i && ip[1:0] != 2'd0 |-> prev_opc[4:3] != PARAM_CLASS);

endmodule

`default_nettype wire

/* verilog/lisp_if.sv */
`default_nettype none

// Single-port memory bus, one cycle read latency
interface mem_bus_if;
	import lisp_pkg::*;

	data_t addr;
	word_t wdata;
	logic  we;
	word_t rdata;

	modport master (output addr, output wdata, output we, input rdata);
	modport slave (input addr, input wdata, input we, output rdata);
endinterface

// Datapath selects driven by the FSM
interface dp_ctrl_if;
	import lisp_pkg::*;

	sp_sel_e  sp_sel;
	tos_sel_e tos_sel;
	op0_sel_e op0_sel;
	op1_sel_e op1_sel;
	opcode_e  alu_op;
	logic     bp_load;
	logic     ir_load;
	ip_sel_e  ip_next_sel;

	modport ctrl (
		output sp_sel, output tos_sel, output op0_sel, output op1_sel,
		output alu_op, output bp_load, output ir_load, output ip_next_sel
	);
	modport fetch (input ir_load, input ip_next_sel);
	modport alu (input op0_sel, input op1_sel, input alu_op);
	modport regs (input sp_sel, input tos_sel, input bp_load);
endinterface

`default_nettype wire

/* verilog/lisp_pkg.sv */
`default_nettype none

package lisp_pkg;

	// Memory and instruction words are 20 bits, data uses the low 16
	typedef logic [19:0] word_t;
	typedef logic [15:0] data_t;

	// Slot address: word address in the upper bits, slot number in the low two
	typedef logic [21:0] iptr_t;

	typedef enum logic [4:0] {
		OP_NOP      = 5'd0,
		OP_CALL     = 5'd1,
		OP_RETURN   = 5'd2,
		OP_POP      = 5'd3,
		OP_LOAD     = 5'd4,
		OP_STORE    = 5'd5,
		OP_ADD      = 5'd6,
		OP_SUB      = 5'd7,
		OP_GTR      = 5'd9,
		OP_GTE      = 5'd10,
		OP_EQ       = 5'd11,
		OP_NEQ      = 5'd12,
		OP_DUP      = 5'd13,
		OP_AND      = 5'd16,
		OP_OR       = 5'd17,
		OP_XOR      = 5'd18,
		OP_LSHIFT   = 5'd19,
		OP_RSHIFT   = 5'd20,
		OP_RESERVE  = 5'd24,
		OP_PUSH     = 5'd25,
		OP_GOTO     = 5'd26,
		OP_BFALSE   = 5'd27,
		OP_GETLOCAL = 5'd29,
		OP_SETLOCAL = 5'd30,
		OP_CLEANUP  = 5'd31
	} opcode_e;

	// Opcodes with these top bits take the rest of the word as a parameter
	localparam logic [1:0] PARAM_CLASS = 2'b11;

	typedef enum logic [3:0] {
		ST_FETCH     = 4'd0,
		ST_DECODE    = 4'd1,
		ST_GOT_NOS   = 4'd2,
		ST_LOAD_TOS  = 4'd3,
		ST_PUSH_MEM  = 4'd4,
		ST_GETLOCAL2 = 4'd5,
		ST_RETURN2   = 4'd6,
		ST_RETURN3   = 4'd7,
		ST_CALL2     = 4'd8
	} state_e;

	typedef enum logic [1:0] {SP_CUR, SP_DEC, SP_INC, SP_ALU} sp_sel_e;

	typedef enum logic [2:0] {TOS_CUR, TOS_RET, TOS_PARAM, TOS_ALU, TOS_MEM, TOS_REG} tos_sel_e;

	typedef enum logic [1:0] {OP0_TOS, OP0_SP, OP0_BP} op0_sel_e;

	typedef enum logic [1:0] {OP1_MEM, OP1_PARAM, OP1_ONE} op1_sel_e;

	typedef enum logic [2:0] {IP_HOLD, IP_SEQ, IP_BRANCH, IP_CALL, IP_RETURN} ip_sel_e;

	// Hardware register window sits at the top of the data address space
	localparam logic [8:0] IO_PREFIX  = 9'h1ff;
	localparam int         IO_INDEX_W = 7;

endpackage

`default_nettype wire
